// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes of the kept subset
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_jal    = 7'b1101111;

  // funct3 for alu ops
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_sr  = 3'b101;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 for branches and memory size
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt
  } alu_op_t;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_j} imm_kind_t;

  // write-back source
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;

endpackage

// ==== verilog/ctrl_if.sv ====
`timescale 1ns/1ns

interface ctrl_if;
  rv_pkg::alu_op_t alu_op;
  logic            use_imm;
  rv_pkg::word_t   imm;
  logic            reg_write;
  logic            mem_write;
  rv_pkg::wb_sel_t wb_sel;
  logic            branch;
  logic            branch_ne;
  logic            jump;

  modport decoder (
    output alu_op, use_imm, imm, reg_write, mem_write, wb_sel,
    output branch, branch_ne, jump
  );

  // operand and write-back muxes
  modport exec (
    input alu_op, use_imm, imm, reg_write, mem_write, wb_sel
  );

  modport pc (input imm, branch, branch_ne, jump);

endinterface

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ns

module pc_unit #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  ctrl_if.pc            ctrl,
  input  logic          equal,
  output rv_pkg::word_t pc
);
  import rv_pkg::*;

  logic  take;
  word_t pc_next;

  // beq takes on equal, bne on not equal
  assign take = ctrl.jump | (ctrl.branch & (equal != ctrl.branch_ne));

  always_comb begin
    if (take) begin
      pc_next = pc + ctrl.imm;
    end else begin
      pc_next = pc + word_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ns

module decoder (
  input  rv_pkg::word_t     instr,
  ctrl_if.decoder           ctrl,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  alu_op_t    f3_op;
  imm_kind_t  imm_kind;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // bit 30 is part of the immediate for addi, so only shifts look at it there
  assign alt = instr[30] & ((opcode == op_reg) | (funct3 == f3_sr));

  always_comb begin
    case (funct3)
      f3_add:  f3_op = alt ? alu_sub : alu_add;
      f3_sll:  f3_op = alu_sll;
      f3_slt:  f3_op = alu_slt;
      f3_xor:  f3_op = alu_xor;
      f3_sr:   f3_op = alt ? alu_sra : alu_srl;
      f3_or:   f3_op = alu_or;
      f3_and:  f3_op = alu_and;
      default: f3_op = alu_add;
    endcase
  end

  always_comb begin
    ctrl.alu_op    = alu_add;
    ctrl.use_imm   = 1'b0;
    ctrl.reg_write = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.wb_sel    = wb_alu;
    ctrl.branch    = 1'b0;
    ctrl.branch_ne = 1'b0;
    ctrl.jump      = 1'b0;
    imm_kind       = imm_i;
    case (opcode)
      op_reg: begin
        ctrl.alu_op    = f3_op;
        ctrl.reg_write = 1'b1;
      end
      op_imm: begin
        ctrl.alu_op    = f3_op;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      op_load: begin
        // word loads only
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = (funct3 == f3_word);
        ctrl.wb_sel    = wb_mem;
      end
      op_store: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = (funct3 == f3_word);
        imm_kind       = imm_s;
      end
      op_branch: begin
        ctrl.branch    = (funct3 == f3_beq) | (funct3 == f3_bne);
        ctrl.branch_ne = (funct3 == f3_bne);
        imm_kind       = imm_b;
      end
      op_jal: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        imm_kind       = imm_j;
      end
      default: begin
        // unknown opcode falls through as a plain pc advance
      end
    endcase
  end

  // sign extension per format
  always_comb begin
    case (imm_kind)
      imm_s: begin
        ctrl.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      imm_b: begin
        ctrl.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      imm_j: begin
        ctrl.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        ctrl.imm = {{20{instr[31]}}, instr[31:20]};
      end
    endcase
  end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ns

module register_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  logic              we,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);
  import rv_pkg::*;

  word_t regs [32];

  // x0 is never written, so it keeps the reset zero
  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // old value on a same-cycle write
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::word_t   cmp_b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::word_t   result,
  output logic            equal
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_sll: result = a << shamt;
      alu_srl: result = a >> shamt;
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_slt: result = word_t'($signed(a) < $signed(b));
      default: result = a + b;
    endcase
  end

  // branch compare on raw register values
  assign equal = (a == cmp_b);

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ns

module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  input  rv_pkg::word_t dmem_rdata
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     rdata1;
  rv_pkg::word_t     rdata2;
  rv_pkg::word_t     alu_b;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     wb_data;
  rv_pkg::word_t     pc;
  logic              equal;

  ctrl_if ctrl ();

  pc_unit #(
    .reset_pc(reset_pc)
  ) u_pc_unit (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl),
    .equal(equal),
    .pc   (pc)
  );

  decoder u_decoder (
    .instr(imem_data),
    .ctrl (ctrl),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  register_file u_register_file (
    .clk   (clk),
    .rst   (rst),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .we    (ctrl.reg_write),
    .wdata (wb_data),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  assign alu_b = ctrl.use_imm ? ctrl.imm : rdata2;

  // equal sees rs2 even when b carries the immediate
  alu u_alu (
    .a     (rdata1),
    .b     (alu_b),
    .cmp_b (rdata2),
    .op    (ctrl.alu_op),
    .result(alu_result),
    .equal (equal)
  );

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_mem:  wb_data = dmem_rdata;
      rv_pkg::wb_link: wb_data = pc + rv_pkg::word_t'(4);
      default:         wb_data = alu_result;
    endcase
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rdata2;
  assign dmem_we    = ctrl.mem_write & ~rst;

endmodule

// ==== bench/rv_core_sva.sv ====
`timescale 1ns/1ns

module rv_core_sva #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t imem_addr,
  input rv_pkg::word_t imem_data,
  input logic          dmem_we,
  input rv_pkg::word_t rdata1,
  input rv_pkg::word_t rdata2
);
  import rv_pkg::*;

  int         fail_count = 0;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       is_branch;
  logic       is_jal;
  logic       taken;
  word_t      b_imm;
  word_t      j_imm;
  word_t      branch_next;
  word_t      jal_next;

  assign opcode    = imem_data[6:0];
  assign funct3    = imem_data[14:12];
  assign is_branch = (opcode == op_branch) && (funct3 == f3_beq || funct3 == f3_bne);
  assign is_jal    = (opcode == op_jal);
  // beq wants a match, bne a difference
  assign taken     = (rdata1 == rdata2) ^ (funct3 == f3_bne);
  assign b_imm = {{20{imem_data[31]}}, imem_data[7], imem_data[30:25], imem_data[11:8], 1'b0};
  assign j_imm = {{12{imem_data[31]}}, imem_data[19:12], imem_data[20], imem_data[30:21], 1'b0};
  assign branch_next = taken ? imem_addr + b_imm : imem_addr + 32'd4;
  assign jal_next    = imem_addr + j_imm;

  a_reset_we: assert property (@(posedge clk) rst |-> !dmem_we)
    else begin
      fail_count++;
      $error("dmem_we high while rst is high");
    end

  a_reset_pc: assert property (@(posedge clk) $past(rst) |-> imem_addr == reset_pc && !dmem_we)
    else begin
      fail_count++;
      $error("imem_addr not at reset_pc or dmem_we high right after reset");
    end

  a_seq_fetch: assert property (@(posedge clk)
    !rst && !is_branch && !is_jal |=> imem_addr == $past(imem_addr) + 32'd4)
    else begin
      fail_count++;
      $error("fetch did not advance by 4 after a plain instruction");
    end

  a_branch: assert property (@(posedge clk) !rst && is_branch |=> imem_addr == $past(branch_next))
    else begin
      fail_count++;
      $error("branch went to the wrong address");
    end

  a_jal: assert property (@(posedge clk) !rst && is_jal |=> imem_addr == $past(jal_next))
    else begin
      fail_count++;
      $error("jal went to the wrong address");
    end

endmodule

bind rv_core rv_core_sva #(
  .reset_pc(reset_pc)
) u_rv_core_sva (
  .clk      (clk),
  .rst      (rst),
  .imem_addr(imem_addr),
  .imem_data(imem_data),
  .dmem_we  (dmem_we),
  .rdata1   (rdata1),
  .rdata2   (rdata2)
);

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;
  import rv_pkg::*;

  logic  clk;
  logic  rst;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  word_t dmem_rdata;

  word_t imem [64];
  word_t dmem [128];

  // one expected store per test
  string name_q [$];
  word_t addr_q [$];
  word_t exp_q [$];
  bit    seen_q [$];

  int    n_instr;
  int    n_pass;
  int    n_fail;
  int    cycles;
  int    max_cycles;
  word_t op_a;
  word_t op_b;
  word_t self_pc;
  word_t boot_instr;

  rv_core #(
    .reset_pc(32'h0)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  assign imem_data  = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[8:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[8:2]] <= dmem_wdata;
    end
  end

  function automatic word_t r_type(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
                                   reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_type(opcode_t op, logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(reg_addr_t base, reg_addr_t src, logic [11:0] imm);
    return {imm[11:5], src, base, f3_word, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t j_type(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic emit(word_t instr);
    imem[n_instr[5:0]] = instr;
    n_instr++;
  endtask

  task automatic expect_store(string name, word_t addr, word_t exp);
    name_q.push_back(name);
    addr_q.push_back(addr);
    exp_q.push_back(exp);
    seen_q.push_back(1'b0);
  endtask

  // next free result slot, counted from 0x80
  task automatic store_result(string name, reg_addr_t src, word_t exp);
    word_t addr;
    addr = word_t'(32'h80 + 4 * addr_q.size());
    emit(s_type(5'd0, src, addr[11:0]));
    expect_store(name, addr, exp);
  endtask

  task automatic reg_test(string name, logic [2:0] f3, logic alt, reg_addr_t rs1,
                          reg_addr_t rs2, word_t exp);
    emit(r_type(f3, alt, 5'd3, rs1, rs2));
    store_result(name, 5'd3, exp);
  endtask

  task automatic imm_test(string name, logic [2:0] f3, logic [11:0] imm, word_t exp);
    emit(i_type(op_imm, f3, 5'd3, 5'd1, imm));
    store_result(name, 5'd3, exp);
  endtask

  task automatic load_program();
    int    i;
    word_t link_pc;
    for (i = 0; i < 64; i++) begin
      // nop carrying its own index
      imem[i[5:0]] = i_type(op_imm, f3_add, 5'd0, 5'd0, 12'(i));
    end
    for (i = 0; i < 128; i++) begin
      dmem[i[6:0]] <= 32'h5a5a_0000 | word_t'(i * 4);
    end
    dmem[0] <= op_a;
    dmem[1] <= op_b;
    emit(i_type(op_load, f3_word, 5'd1, 5'd0, 12'h000));
    emit(i_type(op_load, f3_word, 5'd2, 5'd0, 12'h004));
    reg_test("add", f3_add, 1'b0, 5'd1, 5'd2, op_a + op_b);
    reg_test("sub", f3_add, 1'b1, 5'd1, 5'd2, op_a - op_b);
    reg_test("and", f3_and, 1'b0, 5'd1, 5'd2, op_a & op_b);
    reg_test("or", f3_or, 1'b0, 5'd1, 5'd2, op_a | op_b);
    reg_test("xor", f3_xor, 1'b0, 5'd1, 5'd2, op_a ^ op_b);
    reg_test("sll", f3_sll, 1'b0, 5'd1, 5'd2, op_a << op_b[4:0]);
    reg_test("srl", f3_sr, 1'b0, 5'd1, 5'd2, op_a >> op_b[4:0]);
    reg_test("sra", f3_sr, 1'b1, 5'd1, 5'd2, word_t'($signed(op_a) >>> op_b[4:0]));
    reg_test("slt_ab", f3_slt, 1'b0, 5'd1, 5'd2, {31'b0, $signed(op_a) < $signed(op_b)});
    reg_test("slt_ba", f3_slt, 1'b0, 5'd2, 5'd1, {31'b0, $signed(op_b) < $signed(op_a)});
    imm_test("addi", f3_add, 12'hb2e, op_a + sext12(12'hb2e));
    imm_test("andi", f3_and, 12'hf0f, op_a & sext12(12'hf0f));
    imm_test("ori", f3_or, 12'h123, op_a | sext12(12'h123));
    imm_test("xori", f3_xor, 12'hfff, op_a ^ sext12(12'hfff));
    imm_test("slli", f3_sll, 12'h007, op_a << 7);
    imm_test("srli", f3_sr, 12'h009, op_a >> 9);
    imm_test("srai", f3_sr, 12'h40d, word_t'($signed(op_a) >>> 13));
    // negative offsets from a base of 0x100
    emit(i_type(op_imm, f3_add, 5'd4, 5'd0, 12'h100));
    emit(i_type(op_load, f3_word, 5'd5, 5'd4, 12'hf00));
    emit(s_type(5'd4, 5'd5, 12'hff8));
    expect_store("lw_sw", 32'h0000_00f8, op_a);
    // x6 collects only the adds on the fall-through paths
    emit(b_type(f3_beq, 5'd1, 5'd1, 13'd8));
    emit(i_type(op_imm, f3_add, 5'd6, 5'd0, 12'h001));
    emit(b_type(f3_bne, 5'd1, 5'd1, 13'd8));
    emit(i_type(op_imm, f3_add, 5'd6, 5'd6, 12'h002));
    emit(b_type(f3_bne, 5'd1, 5'd2, 13'd8));
    emit(i_type(op_imm, f3_add, 5'd6, 5'd6, 12'h004));
    emit(b_type(f3_beq, 5'd1, 5'd2, 13'd8));
    emit(i_type(op_imm, f3_add, 5'd6, 5'd6, 12'h008));
    store_result("branch", 5'd6, 32'd10);
    link_pc = word_t'(n_instr * 4);
    emit(j_type(5'd7, 21'd8));
    emit(i_type(op_imm, f3_add, 5'd7, 5'd0, 12'h000));
    store_result("jal_link", 5'd7, link_pc + 32'd4);
    self_pc = word_t'(n_instr * 4);
    emit(j_type(5'd0, 21'd0));
  endtask

  task automatic check_store(word_t addr, word_t data);
    int k;
    k = -1;
    foreach (addr_q[i]) begin
      if (addr_q[i] == addr) begin
        k = i;
      end
    end
    if (k < 0) begin
      n_fail++;
      $display("store of %h went to unexpected address %h", data, addr);
    end else begin
      seen_q[k] = 1'b1;
      assert (data == exp_q[k]) begin
        n_pass++;
        $display("PASS %s", name_q[k]);
      end else begin
        n_fail++;
        $display("FAIL %s expected %h actual %h", name_q[k], exp_q[k], data);
      end
    end
  endtask

  // stores are looked at mid-cycle, before the memory takes them
  always @(negedge clk) begin
    if (!rst && dmem_we) begin
      check_store(dmem_addr, dmem_wdata);
    end
  end

  task automatic check_self_loop();
    bit    ok;
    word_t actual;
    ok = 1'b1;
    actual = self_pc;
    repeat (4) begin
      @(negedge clk);
      assert (imem_addr == self_pc) else begin
        ok = 1'b0;
        actual = imem_addr;
      end
    end
    if (ok) begin
      n_pass++;
      $display("PASS jal_self");
    end else begin
      n_fail++;
      $display("FAIL jal_self expected %h actual %h", self_pc, actual);
    end
  endtask

  initial begin
    cycles = 0;
    wait (max_cycles > 0);
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: program did not reach its final jal within %0d cycles", max_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    n_instr = 0;
    n_pass = 0;
    n_fail = 0;
    void'($urandom(32'he42fafee));
    // sign bit set so the arithmetic shifts see a negative value
    op_a = $urandom() | 32'h8000_0000;
    op_b = $urandom();
    if (op_b == op_a) begin
      op_b = ~op_a;
    end
    load_program();
    max_cycles = 10 * n_instr;
    // a store sits at reset_pc while rst is high
    boot_instr = imem[0];
    imem[0] = s_type(5'd0, 5'd0, 12'h000);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    imem[0] <= boot_instr;
    @(posedge clk);
    while (imem_addr !== self_pc) begin
      @(negedge clk);
    end
    check_self_loop();
    foreach (seen_q[i]) begin
      if (!seen_q[i]) begin
        n_fail++;
        $display("the store for test %s never happened", name_q[i]);
      end
    end
    $display("%0d tests passed, %0d failed, %0d assertion failures",
             n_pass, n_fail, u_dut.u_rv_core_sva.fail_count);
    if (n_fail == 0 && u_dut.u_rv_core_sva.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/pc_unit.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/rv_core.sv
bench/rv_core_sva.sv
bench/tb_rv_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_rv_core
FILELIST  = vlog.f
SIMFLAGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
